/* pr_freeze_bridge.f */
verilog/pcie_axis_pkg.sv
verilog/axis_pipeline_stage.sv
verilog/axis_pipeline.sv
verilog/axis_pr_freeze_bridge.sv
verilog/pr_port_top.sv
verification/tb_pr_freeze_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PR freeze bridge testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_pr_freeze_bridge \
   -f pr_freeze_bridge.f \
   --Mdir obj_dir -o tb_pr_freeze_bridge &&
./obj_dir/tb_pr_freeze_bridge ||
{ echo "Verilator build or simulation returned an error" >&2; exit 1; }

/* verification/tb_pr_freeze_bridge.sv */
// Self-checking testbench for pr_port_top: random beats both ways under back-pressure and freeze

`timescale 1ns/1ns
`default_nettype none

module tb_pr_freeze_bridge
   import pcie_axis_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int N_STREAM     = 16;
   localparam int N_RANDOM     = 64;
   localparam int N_FREEZE     = 64;
   localparam int TOTAL_BEATS  = N_STREAM + N_RANDOM + N_FREEZE;
   localparam int WATCHDOG_NS  = (TOTAL_BEATS * 20 + RESET_CYCLES) * CLK_PERIOD;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       pr_freeze;

   logic       rx_s_valid;
   axis_beat_t rx_s_beat;
   logic       rx_s_ready;
   logic       rx_m_valid;
   axis_beat_t rx_m_beat;
   logic       rx_m_ready;

   logic       tx_s_valid;
   axis_beat_t tx_s_beat;
   logic       tx_s_ready;
   logic       tx_m_valid;
   axis_beat_t tx_m_beat;
   logic       tx_m_ready;

   // ------------------------------------------------------------
   // Stimulus and scoreboard state
   // ------------------------------------------------------------

   integer     seed = 98082;
   int         cyc;
   int         rx_left;
   int         tx_left;
   int         gap_pct;
   int         bp_pct;
   bit         freeze_mode;
   int         frz_cnt;
   int         frz_cycles;
   bit         drained;

   // Handshake seen at the last falling edge, used by the driver
   bit         rx_acc;
   bit         tx_acc;

   int         rx_in_cnt;
   int         tx_in_cnt;
   int         rx_out_cnt;
   int         tx_out_cnt;
   int         rx_first_cyc;
   int         tx_first_cyc;

   // Accepted input beats not yet delivered
   axis_beat_t rx_q[$];
   axis_beat_t tx_q[$];

   pr_port_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pr_freeze  (pr_freeze),
      .rx_s_valid (rx_s_valid),
      .rx_s_beat  (rx_s_beat),
      .rx_s_ready (rx_s_ready),
      .rx_m_valid (rx_m_valid),
      .rx_m_beat  (rx_m_beat),
      .rx_m_ready (rx_m_ready),
      .tx_s_valid (tx_s_valid),
      .tx_s_beat  (tx_s_beat),
      .tx_s_ready (tx_s_ready),
      .tx_m_valid (tx_m_valid),
      .tx_m_beat  (tx_m_beat),
      .tx_m_ready (tx_m_ready)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   task automatic stop_on_error();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
      if (act !== exp) begin
         $display("FAILED time=%0t ns signal=%s expected=%h actual=%h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED time=%0t ns signal=%s expected=%b actual=%b", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   // True with a probability of pct percent
   function automatic bit roll_pct(input int pct);
      return ((($random(seed) & 32'h7fff_ffff) % 100) < pct);
   endfunction

   function automatic axis_beat_t random_beat();
      axis_beat_t b;
      b.tdata        = {$random(seed), $random(seed)};
      b.tkeep        = TKEEP_W'($random(seed));
      b.tlast        = roll_pct(25);
      b.tuser_vendor = TUSER_W'($random(seed));
      return b;
   endfunction

   // Reference model: the oldest undelivered input beat, unchanged
   function automatic axis_beat_t expected_beat(input bit tx_dir);
      if (tx_dir) begin
         return tx_q[0];
      end
      return rx_q[0];
   endfunction

   // One clock of stimulus, called right after a rising edge
   task automatic drive_cycle();
      if (!rx_s_valid || rx_acc) begin
         if (rx_left > 0 && !roll_pct(gap_pct)) begin
            rx_s_valid <= 1'b1;
            rx_s_beat  <= random_beat();
            rx_left--;
         end else begin
            rx_s_valid <= 1'b0;
         end
      end
      if (!tx_s_valid || tx_acc) begin
         if (tx_left > 0 && !roll_pct(gap_pct)) begin
            tx_s_valid <= 1'b1;
            tx_s_beat  <= random_beat();
            tx_left--;
         end else begin
            tx_s_valid <= 1'b0;
         end
      end
      rx_m_ready <= !roll_pct(bp_pct);
      tx_m_ready <= !roll_pct(bp_pct);

      // Freeze windows of 3 to 10 cycles
      if (!freeze_mode) begin
         frz_cnt = 0;
      end else if (frz_cnt > 0) begin
         frz_cnt--;
      end else if (roll_pct(6)) begin
         frz_cnt = 3 + (($random(seed) & 32'h7fff_ffff) % 8);
      end
      pr_freeze <= (frz_cnt > 0);
   endtask

   task automatic run_phase(input int beats, input int gap, input int bp, input bit frz);
      rx_left     = beats;
      tx_left     = beats;
      gap_pct     = gap;
      bp_pct      = bp;
      freeze_mode = frz;
      while (rx_left > 0 || tx_left > 0) begin
         @(posedge clk);
         drive_cycle();
      end
   endtask

   // ------------------------------------------------------------
   // Input monitor, sampled at the falling edge
   // ------------------------------------------------------------

   always @(negedge clk) begin
      if (rst_n !== 1'b1) begin
         rx_acc = 1'b0;
         tx_acc = 1'b0;
      end else begin
         rx_acc = rx_s_valid && rx_s_ready;
         tx_acc = tx_s_valid && tx_s_ready;
         if (rx_acc) begin
            if (rx_in_cnt == 0) begin
               rx_first_cyc = cyc;
            end
            rx_q.push_back(rx_s_beat);
            rx_in_cnt++;
         end
         if (tx_acc) begin
            if (tx_in_cnt == 0) begin
               tx_first_cyc = cyc;
            end
            tx_q.push_back(tx_s_beat);
            tx_in_cnt++;
         end
      end
   end

   // ------------------------------------------------------------
   // Output compare, freeze and latency checks
   // ------------------------------------------------------------

   always @(negedge clk) begin : compare_outputs
      axis_beat_t exp;
      if (rst_n === 1'b1) begin
         if (pr_freeze) begin
            frz_cycles++;
            check_level("tx_m_valid", 1'b0, tx_m_valid);
            check_level("rx_s_ready", 1'b0, rx_s_ready);
         end

         // First beat leaves the empty pipeline exactly PL_DEPTH cycles later
         if (cyc == rx_first_cyc + PL_DEPTH - 1) begin
            check_level("rx_m_valid", 1'b0, rx_m_valid);
         end
         if (cyc == rx_first_cyc + PL_DEPTH) begin
            check_level("rx_m_valid", 1'b1, rx_m_valid);
         end
         if (cyc == tx_first_cyc + PL_DEPTH - 1) begin
            check_level("tx_m_valid", 1'b0, tx_m_valid);
         end
         if (cyc == tx_first_cyc + PL_DEPTH) begin
            check_level("tx_m_valid", 1'b1, tx_m_valid);
         end

         if (rx_m_valid && rx_m_ready) begin
            if (rx_q.size() == 0) begin
               $display("RX output delivered a beat that was never sent, at %0t ns", $time);
               stop_on_error();
            end
            exp = expected_beat(1'b0);
            rx_q.pop_front();
            rx_out_cnt++;
            check_beat("rx_m_beat", exp, rx_m_beat);
         end
         if (tx_m_valid && tx_m_ready) begin
            if (tx_q.size() == 0) begin
               $display("TX output delivered a beat that was never sent, at %0t ns", $time);
               stop_on_error();
            end
            exp = expected_beat(1'b1);
            tx_q.pop_front();
            tx_out_cnt++;
            check_beat("tx_m_beat", exp, tx_m_beat);
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the streams did not drain", WATCHDOG_NS);
      stop_on_error();
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------

   initial begin : main_seq
      rst_n        = 1'b0;
      pr_freeze    = 1'b0;
      rx_s_valid   = 1'b0;
      rx_s_beat    = '0;
      rx_m_ready   = 1'b1;
      tx_s_valid   = 1'b0;
      tx_s_beat    = '0;
      tx_m_ready   = 1'b1;
      cyc          = 0;
      rx_in_cnt    = 0;
      tx_in_cnt    = 0;
      rx_out_cnt   = 0;
      tx_out_cnt   = 0;
      rx_first_cyc = -100;
      tx_first_cyc = -100;
      frz_cnt      = 0;
      frz_cycles   = 0;

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // Idle outputs, open inputs right after reset
      @(negedge clk);
      check_level("rx_m_valid", 1'b0, rx_m_valid);
      check_level("tx_m_valid", 1'b0, tx_m_valid);
      check_level("rx_s_ready", 1'b1, rx_s_ready);
      check_level("tx_s_ready", 1'b1, tx_s_ready);

      run_phase(N_STREAM, 0, 0, 1'b0);
      run_phase(N_RANDOM, 30, 30, 1'b0);
      run_phase(N_FREEZE, 20, 25, 1'b1);

      // Drain with open outputs and no freeze
      gap_pct     = 0;
      bp_pct      = 0;
      freeze_mode = 1'b0;
      drained     = 1'b0;
      while (!drained) begin
         @(negedge clk);
         drained = (rx_out_cnt == rx_in_cnt) && (tx_out_cnt == tx_in_cnt) &&
                   !rx_s_valid && !tx_s_valid;
         if (!drained) begin
            @(posedge clk);
            drive_cycle();
         end
      end
      repeat (4) @(posedge clk);

      if (rx_in_cnt != TOTAL_BEATS || tx_in_cnt != TOTAL_BEATS ||
          rx_out_cnt != rx_in_cnt || tx_out_cnt != tx_in_cnt || frz_cycles == 0) begin
         $display("Beat counts wrong after drain: rx %0d in %0d out, tx %0d in %0d out",
                  rx_in_cnt, rx_out_cnt, tx_in_cnt, tx_out_cnt);
         $display("Planned beats per direction %0d, freeze cycles seen %0d",
                  TOTAL_BEATS, frz_cycles);
         stop_on_error();
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog/axis_pipeline.sv */
// Chain of AXI-Stream register slices; DEPTH sets the number of stages, 0 gives a pass-through

`timescale 1ns/1ns
`default_nettype none

module axis_pipeline
   import pcie_axis_pkg::*;
#(
   parameter int DEPTH = PL_DEPTH,
   parameter int MODE  = STAGE_SKID
) (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       s_valid,
   input  wire axis_beat_t s_beat,
   output logic            s_ready,
   output logic            m_valid,
   output axis_beat_t      m_beat,
   input  wire logic       m_ready
);

   generate
      if (DEPTH == 0) begin : g_bypass
         assign m_valid = s_valid;
         assign m_beat  = s_beat;
         assign s_ready = m_ready;
      end else begin : g_chain
         // Link i feeds stage i, link DEPTH is the chain output
         logic       link_valid [DEPTH+1];
         logic       link_ready [DEPTH+1];
         axis_beat_t link_beat  [DEPTH+1];

         assign link_valid[0] = s_valid;
         assign link_beat[0]  = s_beat;
         assign s_ready       = link_ready[0];

         for (genvar i = 0; i < DEPTH; i++) begin : g_stage
            axis_pipeline_stage #(
               .MODE    (MODE)
            ) stage_i (
               .clk     (clk),
               .rst_n   (rst_n),
               .s_valid (link_valid[i]),
               .s_beat  (link_beat[i]),
               .s_ready (link_ready[i]),
               .m_valid (link_valid[i+1]),
               .m_beat  (link_beat[i+1]),
               .m_ready (link_ready[i+1])
            );
         end

         assign m_valid           = link_valid[DEPTH];
         assign m_beat            = link_beat[DEPTH];
         assign link_ready[DEPTH] = m_ready;
      end
   endgenerate

endmodule

`default_nettype wire

/* verilog/axis_pipeline_stage.sv */
// AXI-Stream register slice: skid buffer with registered ready, or a plain pass-through

`timescale 1ns/1ns
`default_nettype none

module axis_pipeline_stage
   import pcie_axis_pkg::*;
#(
   parameter int MODE = STAGE_SKID
) (
   input  wire logic       clk,
   input  wire logic       rst_n,

   // Upstream side
   input  wire logic       s_valid,
   input  wire axis_beat_t s_beat,
   output logic            s_ready,

   // Downstream side
   output logic            m_valid,
   output axis_beat_t      m_beat,
   input  wire logic       m_ready
);

   generate
      if (MODE == STAGE_SKID) begin : g_skid

         // ------------------------------------------------------------
         // Skid buffer state
         // ------------------------------------------------------------

         logic       main_valid_q;
         axis_beat_t main_beat_q;
         logic       skid_valid_q;
         axis_beat_t skid_beat_q;

         logic       main_free;
         logic       in_fire;

         // Main register can take a new beat this cycle
         assign main_free = m_ready || !main_valid_q;
         assign in_fire   = s_valid && s_ready;

         // Ready comes straight from a flop, so no long path upstream
         assign s_ready = !skid_valid_q;

         assign m_valid = main_valid_q;
         assign m_beat  = main_beat_q;

         // Control flags
         always_ff @(posedge clk) begin
            if (!rst_n) begin
               main_valid_q <= 1'b0;
               skid_valid_q <= 1'b0;
            end else begin
               if (main_free) begin
                  if (skid_valid_q) begin
                     // Drain the parked beat first to keep order
                     main_valid_q <= 1'b1;
                     skid_valid_q <= 1'b0;
                  end else begin
                     main_valid_q <= in_fire;
                  end
               end else if (in_fire) begin
                  // Output stalled, park the incoming beat
                  skid_valid_q <= 1'b1;
               end
            end
         end

         // Payload registers
         always_ff @(posedge clk) begin
            if (main_free) begin
               if (skid_valid_q) begin
                  main_beat_q <= skid_beat_q;
               end else if (in_fire) begin
                  main_beat_q <= s_beat;
               end
            end
            if (in_fire && !main_free) begin
               skid_beat_q <= s_beat;
            end
         end

         // ------------------------------------------------------------
         // Checks
         // ------------------------------------------------------------

         // A stalled output beat must not move or vanish
         a_hold_stalled: assert property (
            @(posedge clk) disable iff (!rst_n)
            (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
         ) else $error("stalled output beat changed");

      end else begin : g_pass

         // No storage, handshake passes straight through
         assign m_valid = s_valid;
         assign m_beat  = s_beat;
         assign s_ready = m_ready;

      end
   endgenerate

endmodule

`default_nettype wire

/* verilog/axis_pr_freeze_bridge.sv */
// PR freeze bridge: registers and freeze-gates both stream directions at the reconfigurable boundary

`timescale 1ns/1ns
`default_nettype none

module axis_pr_freeze_bridge
   import pcie_axis_pkg::*;
#(
   // 1 honours pr_freeze, 0 leaves both gates open
   parameter bit FREEZE_EN = 1'b1,
   parameter int RX_MODE   = STAGE_SKID,
   parameter int TX_MODE   = STAGE_SKID
) (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       pr_freeze,

   // RX, host to function
   input  wire logic       rx_s_valid,
   input  wire axis_beat_t rx_s_beat,
   output logic            rx_s_ready,
   output logic            rx_m_valid,
   output axis_beat_t      rx_m_beat,
   input  wire logic       rx_m_ready,

   // TX, function to host
   input  wire logic       tx_s_valid,
   input  wire axis_beat_t tx_s_beat,
   output logic            tx_s_ready,
   output logic            tx_m_valid,
   output axis_beat_t      tx_m_beat,
   input  wire logic       tx_m_ready
);

   logic       freeze_w;

   // TX pipeline output, before the gate
   logic       tx_pl_valid;
   logic       tx_pl_ready;
   axis_beat_t tx_pl_beat;

   // RX gate output, into the pipeline
   logic       rx_pl_valid;
   logic       rx_pl_ready;
   axis_beat_t rx_pl_beat;

   assign freeze_w = FREEZE_EN && pr_freeze;

   // ------------------------------------------------------------
   // TX path: pipeline, then gate
   // ------------------------------------------------------------

   axis_pipeline #(
      .DEPTH   (PL_DEPTH),
      .MODE    (TX_MODE)
   ) pipe_fn2mx (
      .clk     (clk),
      .rst_n   (rst_n),
      .s_valid (tx_s_valid),
      .s_beat  (tx_s_beat),
      .s_ready (tx_s_ready),
      .m_valid (tx_pl_valid),
      .m_beat  (tx_pl_beat),
      .m_ready (tx_pl_ready)
   );

   // Frozen function side cannot push beats out to the host
   always_comb begin
      tx_m_valid  = tx_pl_valid;
      tx_m_beat   = tx_pl_beat;
      tx_pl_ready = tx_m_ready;
      if (freeze_w) begin
         tx_m_valid  = 1'b0;
         tx_pl_ready = 1'b0;
      end
   end

   // ------------------------------------------------------------
   // RX path: gate, then pipeline
   // ------------------------------------------------------------

   always_comb begin
      rx_pl_valid = rx_s_valid;
      rx_pl_beat  = rx_s_beat;
      rx_s_ready  = rx_pl_ready;
      if (freeze_w) begin
         rx_pl_valid = 1'b0;
         rx_s_ready  = 1'b0;
      end
   end

   axis_pipeline #(
      .DEPTH   (PL_DEPTH),
      .MODE    (RX_MODE)
   ) pipe_mx2fn (
      .clk     (clk),
      .rst_n   (rst_n),
      .s_valid (rx_pl_valid),
      .s_beat  (rx_pl_beat),
      .s_ready (rx_pl_ready),
      .m_valid (rx_m_valid),
      .m_beat  (rx_m_beat),
      .m_ready (rx_m_ready)
   );

   // Nothing crosses the boundary on either side while frozen
   a_freeze_blocks: assert property (
      @(posedge clk) disable iff (!rst_n)
      (FREEZE_EN && pr_freeze) |-> (!tx_m_valid && !rx_s_ready)
   ) else $error("beat handshake open during freeze");

endmodule

`default_nettype wire

/* verilog/pcie_axis_pkg.sv */
// Stream widths, pipeline depth and beat type that every RTL module of the PR freeze bridge imports

`default_nettype none

package pcie_axis_pkg;

   // ------------------------------------------------------------
   // Stream widths
   // ------------------------------------------------------------

   // Data bus width in bits
   localparam int TDATA_W = 64;

   // One byte enable per data byte
   localparam int TKEEP_W = TDATA_W / 8;

   // Vendor sideband carried through untouched
   localparam int TUSER_W = 10;

   // ------------------------------------------------------------
   // Pipeline configuration
   // ------------------------------------------------------------

   // Register stages in each direction
   localparam int PL_DEPTH = 2;

   // Stage mode encodings
   localparam int STAGE_SKID = 0;
   localparam int STAGE_PASS = 1;

   // ------------------------------------------------------------
   // Beat type
   // ------------------------------------------------------------

   // One AXI-Stream beat of 83 bits with the widths above
   typedef struct packed {
      logic [TDATA_W-1:0] tdata;
      logic [TKEEP_W-1:0] tkeep;
      logic               tlast;
      logic [TUSER_W-1:0] tuser_vendor;
   } axis_beat_t;

endpackage

`default_nettype wire

/* verilog/pr_port_top.sv */
// Top level of the PCIe streaming port, joining static-side and function-side streams via the bridge

`timescale 1ns/1ns
`default_nettype none

module pr_port_top
   import pcie_axis_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       pr_freeze,

   // Host into port
   input  wire logic       rx_s_valid,
   input  wire axis_beat_t rx_s_beat,
   output logic            rx_s_ready,

   // Port to function
   output logic            rx_m_valid,
   output axis_beat_t      rx_m_beat,
   input  wire logic       rx_m_ready,

   // Function into port
   input  wire logic       tx_s_valid,
   input  wire axis_beat_t tx_s_beat,
   output logic            tx_s_ready,

   // Port to host
   output logic            tx_m_valid,
   output axis_beat_t      tx_m_beat,
   input  wire logic       tx_m_ready
);

   // Freeze gating on, skid slices in both directions
   axis_pr_freeze_bridge #(
      .FREEZE_EN  (1'b1),
      .RX_MODE    (STAGE_SKID),
      .TX_MODE    (STAGE_SKID)
   ) bridge_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pr_freeze  (pr_freeze),
      .rx_s_valid (rx_s_valid),
      .rx_s_beat  (rx_s_beat),
      .rx_s_ready (rx_s_ready),
      .rx_m_valid (rx_m_valid),
      .rx_m_beat  (rx_m_beat),
      .rx_m_ready (rx_m_ready),
      .tx_s_valid (tx_s_valid),
      .tx_s_beat  (tx_s_beat),
      .tx_s_ready (tx_s_ready),
      .tx_m_valid (tx_m_valid),
      .tx_m_beat  (tx_m_beat),
      .tx_m_ready (tx_m_ready)
   );

endmodule

`default_nettype wire
